/* iadc_pkg.sv */
package iadc_pkg;

  localparam int LANE_W   = 8;                      // one adc lane byte.
  localparam int SAMPLE_W = 8 * LANE_W;             // four lanes, two edges.
  localparam int OOR_W    = 4;                      // i/q flags on both edges.
  localparam int ADDR_W   = 3;
  localparam int DATA_W   = 16;
  localparam int CREDIT_W = 4;
  localparam int TICK_W   = 16;

  // serial register frame, address first then data.
  localparam int FRAME_BITS = ADDR_W + DATA_W;
  localparam int BIT_CNT_W  = $clog2(FRAME_BITS);

  typedef logic [LANE_W-1:0]   lane_t;
  typedef logic [SAMPLE_W-1:0] sample_t;
  typedef logic [OOR_W-1:0]    oor_t;
  typedef logic [ADDR_W-1:0]   reg_addr_t;
  typedef logic [DATA_W-1:0]   reg_data_t;
  typedef logic [CREDIT_W-1:0] credit_t;
  typedef logic [TICK_W-1:0]   tick_t;

  typedef enum logic [2:0] {
    IDLE,        // leaves on the first cycle after reset.
    RESET_ADC,   // ddrb pulse to the adc.
    WAIT_LOCK,   // clock manager settling.
    RUN,
    CONFIG,      // serial register write in flight.
    FAULT        // lock never arrived, held until reset.
  } seq_state_t;

endpackage

/* iadc_timer.sv */
`timescale 1ns/1ps

module iadc_timer (
  input  logic            adc_clk,
  input  logic            arst_n,
  input  logic            load,
  input  iadc_pkg::tick_t count,
  output logic            expired
);
  import iadc_pkg::*;

  tick_t cnt;
  logic  running;

  // fires once the loaded count has run down to zero.
  assign expired = running && (cnt == '0);

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt     <= '0;
      running <= 1'b0;
    end else if (load) begin
      cnt     <= count;
      running <= 1'b1;
    end else if (running) begin
      if (cnt == '0) begin
        running <= 1'b0;   // one-shot, waits for the next load.
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

/* iadc_ddr_capture.sv */
`timescale 1ns/1ps

module iadc_ddr_capture (
  input  logic              adc_clk,
  input  logic              arst_n,
  input  logic              capture_run,
  input  iadc_pkg::lane_t   adc_data_i_even,
  input  iadc_pkg::lane_t   adc_data_i_odd,
  input  iadc_pkg::lane_t   adc_data_q_even,
  input  iadc_pkg::lane_t   adc_data_q_odd,
  input  logic              adc_outofrange_i,
  input  logic              adc_outofrange_q,
  input  logic              adc_sync,
  output logic              cap_valid,
  output iadc_pkg::sample_t cap_data,
  output iadc_pkg::oor_t    cap_oor,
  output logic              cap_sync
);
  import iadc_pkg::*;

  lane_t i_even_r;
  lane_t i_odd_r;
  lane_t q_even_r;
  lane_t q_odd_r;
  lane_t i_even_f;
  lane_t i_odd_f;
  lane_t q_even_f;
  lane_t q_odd_f;
  logic  oor_i_r;
  logic  oor_q_r;
  logic  oor_i_f;
  logic  oor_q_f;
  logic  sync_r;
  logic  run_r;

  always_ff @(posedge adc_clk) begin
    i_even_r <= adc_data_i_even;
    i_odd_r  <= adc_data_i_odd;
    q_even_r <= adc_data_q_even;
    q_odd_r  <= adc_data_q_odd;
    oor_i_r  <= adc_outofrange_i;
    oor_q_r  <= adc_outofrange_q;
    sync_r   <= adc_sync;         // sync is only taken on the rising edge.
  end

  always_ff @(negedge adc_clk) begin
    i_even_f <= adc_data_i_even;
    i_odd_f  <= adc_data_i_odd;
    q_even_f <= adc_data_q_even;
    q_odd_f  <= adc_data_q_odd;
    oor_i_f  <= adc_outofrange_i;
    oor_q_f  <= adc_outofrange_q;
  end

  // valid follows the rising-edge half through both pipeline stages.
  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      run_r     <= 1'b0;
      cap_valid <= 1'b0;
    end else begin
      run_r     <= capture_run;
      cap_valid <= run_r;
    end
  end

  // both halves of one cycle land together here.
  always_ff @(posedge adc_clk) begin
    cap_data <= {i_even_r, i_odd_r, i_even_f, i_odd_f,
                 q_even_r, q_odd_r, q_even_f, q_odd_f};
    cap_oor  <= {oor_i_f, oor_q_f, oor_i_r, oor_q_r};
    cap_sync <= sync_r;
  end

endmodule

/* iadc_sample_fifo.sv */
`timescale 1ns/1ps

module iadc_sample_fifo #(
  parameter int FIFO_DEPTH = 8,
  parameter int CREDITS    = 4
) (
  input  logic              adc_clk,
  input  logic              arst_n,
  input  logic              cap_valid,
  input  iadc_pkg::sample_t cap_data,
  input  iadc_pkg::oor_t    cap_oor,
  input  logic              cap_sync,
  input  logic              credit_return,
  output logic              sample_valid,
  output iadc_pkg::sample_t sample_data,
  output iadc_pkg::oor_t    sample_oor,
  output logic              sample_sync,
  output iadc_pkg::tick_t   drop_count
);
  import iadc_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  sample_t          mem_data [FIFO_DEPTH];
  oor_t             mem_oor  [FIFO_DEPTH];
  logic             mem_sync [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] fill;
  credit_t          credits;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  assign full  = (fill == CNT_W'(FIFO_DEPTH));
  assign empty = (fill == '0);
  assign push  = cap_valid && !full;              // full means the word is lost.
  assign pop   = !empty && (credits != '0);

  always_ff @(posedge adc_clk) begin
    if (push) begin
      mem_data[wr_ptr] <= cap_data;
      mem_oor[wr_ptr]  <= cap_oor;
      mem_sync[wr_ptr] <= cap_sync;
    end
    if (pop) begin
      sample_data <= mem_data[rd_ptr];
      sample_oor  <= mem_oor[rd_ptr];
      sample_sync <= mem_sync[rd_ptr];
    end
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      fill         <= '0;
      credits      <= credit_t'(CREDITS);
      sample_valid <= 1'b0;
      drop_count   <= '0;
    end else begin
      sample_valid <= pop;                        // one pulse per issued word.
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      case ({pop, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
      if (cap_valid && full) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

endmodule

/* iadc_ctrl_serial.sv */
`timescale 1ns/1ps

module iadc_ctrl_serial #(
  parameter int CTRL_DIV = 4
) (
  input  logic                adc_clk,
  input  logic                arst_n,
  input  logic                start,
  input  iadc_pkg::reg_addr_t addr,
  input  iadc_pkg::reg_data_t data,
  output logic                busy,
  output logic                done,
  output logic                adc_ctrl_clk,
  output logic                adc_ctrl_data,
  output logic                adc_ctrl_strobe_n
);
  import iadc_pkg::*;

  localparam int DIV_W = $clog2(CTRL_DIV + 1);

  logic [FRAME_BITS-1:0] shreg;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [DIV_W-1:0]      div_cnt;
  logic                  active;
  logic                  half_end;

  assign half_end      = (div_cnt == DIV_W'(CTRL_DIV - 1));
  assign adc_ctrl_data = shreg[FRAME_BITS-1];    // msb first.

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      shreg             <= '0;
      bit_cnt           <= '0;
      div_cnt           <= '0;
      active            <= 1'b0;
      busy              <= 1'b0;
      done              <= 1'b0;
      adc_ctrl_clk      <= 1'b0;
      adc_ctrl_strobe_n <= 1'b1;
    end else if (active) begin
      if (half_end) begin
        div_cnt      <= '0;
        adc_ctrl_clk <= !adc_ctrl_clk;
        if (adc_ctrl_clk) begin                  // falling edge, next bit.
          if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1)) begin
            active            <= 1'b0;
            adc_ctrl_strobe_n <= 1'b1;
            done              <= 1'b1;           // trailing cycle, strobe high.
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
            shreg   <= {shreg[FRAME_BITS-2:0], 1'b0};
          end
        end
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end else if (done) begin
      done <= 1'b0;
      busy <= 1'b0;
    end else if (start && !busy) begin
      shreg             <= {addr, data};
      bit_cnt           <= '0;
      div_cnt           <= '0;
      active            <= 1'b1;
      busy              <= 1'b1;
      adc_ctrl_clk      <= 1'b0;                 // each bit opens low.
      adc_ctrl_strobe_n <= 1'b0;
    end
  end

endmodule

/* iadc_seq_fsm.sv */
`timescale 1ns/1ps

module iadc_seq_fsm #(
  parameter int DDRB_CYCLES  = 16,
  parameter int LOCK_TIMEOUT = 200
) (
  input  logic                adc_clk,
  input  logic                arst_n,
  input  logic                clk_lock,
  input  logic                capture_en,
  input  logic                cfg_start,
  input  iadc_pkg::reg_addr_t cfg_addr,
  input  iadc_pkg::reg_data_t cfg_data,
  input  logic                timer_expired,
  input  logic                ser_done,
  output logic                adc_ddrb,
  output logic                ready,
  output logic                lock_fail,
  output logic                cfg_busy,
  output logic                capture_run,
  output logic                timer_load,
  output iadc_pkg::tick_t     timer_count,
  output logic                ser_start,
  output iadc_pkg::reg_addr_t ser_addr,
  output iadc_pkg::reg_data_t ser_data
);
  import iadc_pkg::*;

  seq_state_t state;
  seq_state_t state_nxt;
  logic       cfg_accept;

  // a write request only counts while running with lock.
  assign cfg_accept  = (state == RUN) && clk_lock && cfg_start;

  assign adc_ddrb    = (state == RESET_ADC);
  assign ready       = (state == RUN);
  assign lock_fail   = (state == FAULT);
  assign cfg_busy    = (state == CONFIG);
  assign capture_run = ((state == RUN) || (state == CONFIG)) && capture_en;

  // timer counts are one short, the expiry cycle itself completes the span.
  always_comb begin
    state_nxt   = state;
    timer_load  = 1'b0;
    timer_count = tick_t'(DDRB_CYCLES - 1);
    case (state)
      IDLE: begin
        state_nxt  = RESET_ADC;
        timer_load = 1'b1;
      end
      RESET_ADC: begin
        if (timer_expired) begin
          state_nxt   = WAIT_LOCK;
          timer_load  = 1'b1;
          timer_count = tick_t'(LOCK_TIMEOUT - 1);
        end
      end
      WAIT_LOCK: begin
        if (clk_lock) begin
          state_nxt = RUN;
        end else if (timer_expired) begin
          state_nxt = FAULT;
        end
      end
      RUN: begin
        if (!clk_lock) begin
          state_nxt  = RESET_ADC;                // lost lock, reset the adc again.
          timer_load = 1'b1;
        end else if (cfg_accept) begin
          state_nxt = CONFIG;
        end
      end
      CONFIG: begin
        if (ser_done) begin
          state_nxt = RUN;
        end
      end
      FAULT:   state_nxt = FAULT;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge adc_clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= IDLE;
      ser_start <= 1'b0;
    end else begin
      state     <= state_nxt;
      ser_start <= cfg_accept;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (cfg_accept) begin
      ser_addr <= cfg_addr;
      ser_data <= cfg_data;
    end
  end

endmodule

/* iadc_top.sv */
`timescale 1ns/1ps

module iadc_top #(
  parameter int FIFO_DEPTH   = 8,
  parameter int CREDITS      = 4,
  parameter int DDRB_CYCLES  = 16,
  parameter int LOCK_TIMEOUT = 200,
  parameter int CTRL_DIV     = 4
) (
  input  logic                adc_clk,
  input  logic                arst_n,
  input  logic                clk_lock,
  input  iadc_pkg::lane_t     adc_data_i_even,
  input  iadc_pkg::lane_t     adc_data_i_odd,
  input  iadc_pkg::lane_t     adc_data_q_even,
  input  iadc_pkg::lane_t     adc_data_q_odd,
  input  logic                adc_outofrange_i,
  input  logic                adc_outofrange_q,
  input  logic                adc_sync,
  input  logic                capture_en,
  input  logic                cfg_start,
  input  iadc_pkg::reg_addr_t cfg_addr,
  input  iadc_pkg::reg_data_t cfg_data,
  input  logic                credit_return,
  output logic                adc_ddrb,
  output logic                adc_ctrl_clk,
  output logic                adc_ctrl_data,
  output logic                adc_ctrl_strobe_n,
  output logic                sample_valid,
  output iadc_pkg::sample_t   sample_data,
  output iadc_pkg::oor_t      sample_oor,
  output logic                sample_sync,
  output iadc_pkg::tick_t     drop_count,
  output logic                ready,
  output logic                lock_fail,
  output logic                cfg_busy
);
  import iadc_pkg::*;

  logic      capture_run;
  logic      cap_valid;
  sample_t   cap_data;
  oor_t      cap_oor;
  logic      cap_sync;
  logic      timer_load;
  tick_t     timer_count;
  logic      timer_expired;
  logic      ser_start;
  reg_addr_t ser_addr;
  reg_data_t ser_data;
  logic      ser_done;

  iadc_ddr_capture u_capture (
    .adc_clk, .arst_n, .capture_run,
    .adc_data_i_even, .adc_data_i_odd, .adc_data_q_even, .adc_data_q_odd,
    .adc_outofrange_i, .adc_outofrange_q, .adc_sync,
    .cap_valid, .cap_data, .cap_oor, .cap_sync
  );

  iadc_sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .CREDITS(CREDITS)) u_fifo (
    .adc_clk, .arst_n, .cap_valid, .cap_data, .cap_oor, .cap_sync, .credit_return,
    .sample_valid, .sample_data, .sample_oor, .sample_sync, .drop_count
  );

  iadc_ctrl_serial #(.CTRL_DIV(CTRL_DIV)) u_serial (
    .adc_clk, .arst_n, .start(ser_start), .addr(ser_addr), .data(ser_data),
    .busy(), .done(ser_done),
    .adc_ctrl_clk, .adc_ctrl_data, .adc_ctrl_strobe_n
  );

  iadc_timer u_timer (
    .adc_clk, .arst_n, .load(timer_load), .count(timer_count), .expired(timer_expired)
  );

  iadc_seq_fsm #(.DDRB_CYCLES(DDRB_CYCLES), .LOCK_TIMEOUT(LOCK_TIMEOUT)) u_seq (
    .adc_clk, .arst_n, .clk_lock, .capture_en, .cfg_start, .cfg_addr, .cfg_data,
    .timer_expired, .ser_done,
    .adc_ddrb, .ready, .lock_fail, .cfg_busy, .capture_run,
    .timer_load, .timer_count, .ser_start, .ser_addr, .ser_data
  );

endmodule

/* tb_adc_model.sv */
`timescale 1ns/1ps

module tb_adc_model #(
  parameter int LOCK_DELAY = 10
) (
  input  logic            adc_clk,
  input  logic            capture_en,
  input  logic            lock_enable,
  input  logic            adc_ddrb,
  input  logic            adc_ctrl_clk,
  input  logic            adc_ctrl_data,
  input  logic            adc_ctrl_strobe_n,
  output iadc_pkg::lane_t adc_data_i_even,
  output iadc_pkg::lane_t adc_data_i_odd,
  output iadc_pkg::lane_t adc_data_q_even,
  output iadc_pkg::lane_t adc_data_q_odd,
  output logic            adc_outofrange_i,
  output logic            adc_outofrange_q,
  output logic            adc_sync,
  output logic            clk_lock
);
  import iadc_pkg::*;

  // each queue entry holds {sync, oor_i_r, oor_q_r, oor_i_f, oor_q_f,
  // ie_r, io_r, qe_r, qo_r, ie_f, io_f, qe_f, qo_f}.
  logic [68:0] word_q [$];
  logic [18:0] frame_q [$];                       // {addr, data} per decoded frame.
  logic [34:0] r_half;
  logic        r_run;
  logic [18:0] shift;
  int          bits;
  int          lock_cnt;

  initial begin
    {adc_data_i_even, adc_data_i_odd, adc_data_q_even, adc_data_q_odd} = '0;
    {adc_outofrange_i, adc_outofrange_q, adc_sync, clk_lock} = '0;
    r_run    = 1'b0;
    bits     = 0;
    lock_cnt = 0;
  end

  // rising half is latched here while falling-half values go out.
  always @(posedge adc_clk) begin
    r_half = {adc_sync, adc_outofrange_i, adc_outofrange_q, adc_data_i_even,
              adc_data_i_odd, adc_data_q_even, adc_data_q_odd};
    r_run  = capture_en;
    {adc_data_i_even, adc_data_i_odd, adc_data_q_even, adc_data_q_odd} <= $urandom;
    {adc_outofrange_i, adc_outofrange_q} <= 2'($urandom);
  end

  always @(negedge adc_clk) begin
    if (r_run) begin
      word_q.push_back({r_half[34:32], adc_outofrange_i, adc_outofrange_q, r_half[31:0],
                        adc_data_i_even, adc_data_i_odd, adc_data_q_even, adc_data_q_odd});
    end
    {adc_data_i_even, adc_data_i_odd, adc_data_q_even, adc_data_q_odd} <= $urandom;
    {adc_outofrange_i, adc_outofrange_q, adc_sync} <= 3'($urandom);
  end

  // lock follows the end of the ddrb pulse after a fixed settle time.
  always @(posedge adc_clk) begin
    if (adc_ddrb || !lock_enable) begin
      clk_lock <= 1'b0;
      lock_cnt <= 0;
    end else if (!clk_lock) begin
      if (lock_cnt == LOCK_DELAY) clk_lock <= 1'b1;
      else lock_cnt <= lock_cnt + 1;
    end
  end

  always @(posedge adc_ctrl_clk) begin
    if (!adc_ctrl_strobe_n) begin
      shift = {shift[17:0], adc_ctrl_data};
      bits  = bits + 1;
    end
  end

  always @(posedge adc_ctrl_strobe_n) begin
    if (bits == FRAME_BITS) frame_q.push_back(shift);
    bits = 0;
  end

endmodule

/* tb_iadc.sv */
`timescale 1ns/1ps

module tb_iadc;
  import iadc_pkg::*;

  localparam int CLK_NS      = 20;
  localparam int TEST_CYCLES = 8 + 80 + 120 + 120 + 420 + 300;   // reset plus five tests.
  localparam int WATCHDOG_NS = TEST_CYCLES * CLK_NS * 12 / 10;

  logic      clk = 1'b0;
  logic      arst_n;
  logic      capture_en;
  logic      cfg_start;
  reg_addr_t cfg_addr;
  reg_data_t cfg_data;
  logic      credit_return;
  logic      lock_enable;
  lane_t     i_even, i_odd, q_even, q_odd;
  logic      oor_i, oor_q, sync, clk_lock;
  logic      adc_ddrb, ctrl_clk, ctrl_data, ctrl_strobe_n;
  logic      sample_valid, sample_sync, ready, lock_fail, cfg_busy;
  sample_t   sample_data;
  oor_t      sample_oor;
  tick_t     drop_count;
  int        err_count = 0;
  int        tests_failed = 0;
  int        rx_count = 0;
  int        credit_pending = 0;
  logic      auto_credit = 1'b0;

  always #(CLK_NS / 2) clk = ~clk;

  iadc_top u_dut (
    .adc_clk(clk), .arst_n, .clk_lock,
    .adc_data_i_even(i_even), .adc_data_i_odd(i_odd),
    .adc_data_q_even(q_even), .adc_data_q_odd(q_odd),
    .adc_outofrange_i(oor_i), .adc_outofrange_q(oor_q), .adc_sync(sync),
    .capture_en, .cfg_start, .cfg_addr, .cfg_data, .credit_return,
    .adc_ddrb, .adc_ctrl_clk(ctrl_clk), .adc_ctrl_data(ctrl_data),
    .adc_ctrl_strobe_n(ctrl_strobe_n), .sample_valid, .sample_data, .sample_oor,
    .sample_sync, .drop_count, .ready, .lock_fail, .cfg_busy
  );

  tb_adc_model u_model (
    .adc_clk(clk), .capture_en, .lock_enable,
    .adc_ddrb, .adc_ctrl_clk(ctrl_clk), .adc_ctrl_data(ctrl_data),
    .adc_ctrl_strobe_n(ctrl_strobe_n),
    .adc_data_i_even(i_even), .adc_data_i_odd(i_odd), .adc_data_q_even(q_even),
    .adc_data_q_odd(q_odd), .adc_outofrange_i(oor_i), .adc_outofrange_q(oor_q),
    .adc_sync(sync), .clk_lock
  );

  // {sync, oor word, sample word} from one model entry.
  function automatic logic [68:0] pack_word(input logic [68:0] e);
    return {e[68], e[65], e[64], e[67], e[66],
            e[63:56], e[55:48], e[31:24], e[23:16],
            e[47:40], e[39:32], e[15:8], e[7:0]};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("error at %0t: %s", $time, what);
    err_count++;
  endtask

  task automatic finish_test(input string name, input int err_before);
    if (err_count != err_before) tests_failed++;
    $display("test %s: %s", name, (err_count == err_before) ? "ok" : "failed");
  endtask

  always @(posedge clk) begin
    logic [68:0] exp;
    credit_return <= 1'b0;
    if (arst_n && sample_valid) begin
      if (u_model.word_q.size() == 0) begin
        report_failure("sample_valid with no captured word pending");
      end else begin
        exp = pack_word(u_model.word_q.pop_front());
        check_value("sample_data", sample_data, exp[63:0]);
        check_value("sample_oor", 64'(sample_oor), 64'(exp[67:64]));
        check_value("sample_sync", 64'(sample_sync), 64'(exp[68]));
      end
      rx_count++;
    end
    if (auto_credit && sample_valid) begin
      credit_return <= 1'b1;
    end else if (credit_pending > 0) begin
      credit_return <= 1'b1;
      credit_pending--;
    end
  end

  // counts the ddrb pulse that is already high or about to rise.
  task automatic measure_ddrb(output int n);
    n = 0;
    while (!adc_ddrb && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!adc_ddrb) report_failure("adc_ddrb never asserted");
    n = 0;
    while (adc_ddrb && n < 40) begin
      @(negedge clk);
      n++;
      check_value("ready/valid/lock_fail/cfg_busy",
                  64'({ready, sample_valid, lock_fail, cfg_busy}), 64'(0));
    end
  endtask

  task automatic run_capture(input int cycles);
    @(posedge clk);
    capture_en <= 1'b1;
    repeat (cycles) @(posedge clk);
    capture_en <= 1'b0;
  endtask

  task automatic pulse_cfg(input reg_addr_t a, input reg_data_t d);
    @(posedge clk);
    cfg_start <= 1'b1;
    cfg_addr  <= a;
    cfg_data  <= d;
    @(posedge clk);
    cfg_start <= 1'b0;
  endtask

  initial begin
    int          n;
    int          e0;
    int          rx0;
    tick_t       drop0;
    reg_addr_t   a;
    reg_data_t   d;
    logic [18:0] frame;
    n = $urandom(32'he8a29443);
    arst_n        = 1'b0;
    capture_en    = 1'b0;
    cfg_start     = 1'b0;
    cfg_addr      = '0;
    cfg_data      = '0;
    credit_return = 1'b0;
    lock_enable   = 1'b1;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;

    e0 = err_count;
    measure_ddrb(n);
    check_value("adc_ddrb cycles", 64'(n), 64'(16));
    n = 0;
    while (!ready && n < 60) begin
      check_value("valid/lock_fail/cfg_busy", 64'({sample_valid, lock_fail, cfg_busy}), 64'(0));
      @(negedge clk);
      n++;
    end
    if (!ready) report_failure("ready never rose after bring-up");
    check_value("clk_lock", 64'(clk_lock), 64'(1));
    finish_test("bring-up", e0);

    e0 = err_count;
    rx0 = rx_count;
    auto_credit = 1'b1;
    run_capture(64);
    n = 0;
    while (rx_count < rx0 + 64 && n < 60) begin
      @(negedge clk);
      n++;
    end
    check_value("words received", 64'(rx_count - rx0), 64'(64));
    check_value("drop_count", 64'(drop_count), 64'(0));
    finish_test("capture order", e0);

    e0 = err_count;
    repeat (4) @(negedge clk);                  // last credit back home.
    auto_credit = 1'b0;
    rx0 = rx_count;
    drop0 = drop_count;
    run_capture(20);
    repeat (12) @(negedge clk);
    check_value("words without credit", 64'(rx_count - rx0), 64'(4));
    check_value("drop_count", 64'(drop_count - drop0), 64'(20 - 4 - 8));
    repeat (8) void'(u_model.word_q.pop_back()); // newest words were the dropped ones.
    auto_credit = 1'b1;
    credit_pending = 4;
    n = 0;
    while (rx_count < rx0 + 12 && n < 60) begin
      @(negedge clk);
      n++;
    end
    check_value("words after credits", 64'(rx_count - rx0), 64'(12));
    finish_test("credit back-pressure", e0);

    e0 = err_count;
    a = 3'($urandom);
    d = 16'($urandom);
    pulse_cfg(a, d);
    n = 0;
    while (!cfg_busy && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!cfg_busy) report_failure("cfg_busy never rose");
    pulse_cfg(~a, ~d);                          // lands while busy.
    n = 0;
    while (cfg_busy && n < 200) begin
      @(negedge clk);
      n++;
    end
    if (cfg_busy) report_failure("cfg_busy stuck high");
    check_value("ctrl_strobe_n", 64'(ctrl_strobe_n), 64'(1));
    repeat (200) @(negedge clk);
    check_value("frames decoded", 64'(u_model.frame_q.size()), 64'(1));
    if (u_model.frame_q.size() > 0) begin
      frame = u_model.frame_q.pop_front();
      check_value("frame addr", 64'(frame[18:16]), 64'(a));
      check_value("frame data", 64'(frame[15:0]), 64'(d));
    end
    finish_test("serial configuration", e0);

    e0 = err_count;
    @(posedge clk);
    lock_enable <= 1'b0;
    measure_ddrb(n);
    check_value("adc_ddrb cycles", 64'(n), 64'(16));
    n = 0;
    while (!lock_fail && n < 260) begin
      check_value("ready", 64'(ready), 64'(0));
      @(negedge clk);
      n++;
    end
    check_value("cycles to lock_fail", 64'(n), 64'(200));
    finish_test("lock faults", e0);

    $display("tests run 5, tests failed %0d, errors %0d", tests_failed, err_count);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the run did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule

/* flist.f */
iadc_pkg.sv
iadc_timer.sv
iadc_ddr_capture.sv
iadc_sample_fifo.sv
iadc_ctrl_serial.sv
iadc_seq_fsm.sv
iadc_top.sv
tb_adc_model.sv
tb_iadc.sv
